// File: verif/simple_system_tests.txt
# op addr be wdata exp_rdata exp_err check  (hex, hex, hex, hex, hex, dec, dec)
# R/W read/write, RB/WB back-to-back, T read mtime, C write last mtime+wdata, I wait irq=wdata
I  00000000 0 00000000 00000000 0 0
W  00100000 f 11223344 00000000 0 0
R  00100000 f 00000000 11223344 0 1
W  00100004 f a5a5a5a5 00000000 0 0
W  00100004 2 0000ee00 00000000 0 0
W  00100004 9 77000088 00000000 0 0
R  00100004 f 00000000 77a5ee88 0 1
W  00101000 f cafef00d 00000000 0 0
R  00100000 f 00000000 cafef00d 0 1
W  00100010 f 01010101 00000000 0 0
WB 00100014 f 02020202 00000000 0 0
RB 00100010 f 00000000 01010101 0 1
RB 00100014 f 00000000 02020202 0 1
RB 00020004 f 00000000 00000000 0 1
RB 00040000 f 00000000 00000000 1 1
R  00030010 f 00000000 00000000 1 1
W  00020000 1 00000041 00000000 0 0
W  00020000 2 00004200 00000000 0 0
W  00020000 f 0000000a 00000000 0 0
W  00020008 f 00000001 00000000 0 0
T  00030000 f 00000000 00000000 0 0
T  00030000 f 00000000 00000000 0 0
W  0003000c f 00000000 00000000 0 0
R  0003000c f 00000000 00000000 0 1
T  00030000 f 00000000 00000000 0 0
C  00030008 f 00000028 00000000 0 0
I  00000000 0 00000001 00000000 0 0
W  00030008 f ffffffff 00000000 0 0
W  0003000c f ffffffff 00000000 0 0
I  00000000 0 00000000 00000000 0 0

// File: list.f
design/simple_sys_pkg.sv
design/dev_bus_if.sv
design/addr_bus.sv
design/sram_1p.sv
design/sim_ctrl.sv
design/mtimer.sv
design/simple_system.sv
verif/tb_simple_system.sv

// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert
TOP     = tb_simple_system
FILES   = list.f
OUT_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OUT_DIR)
	@out="$$(./$(OUT_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OUT_DIR)

// File: verif/tb_simple_system.sv
`timescale 1ns/1ns
// Plays the host; reads verif/simple_system_tests.txt relative to the project root
// RAM words must be fully written before a partial write or a checked read
module tb_simple_system import simple_sys_pkg::*; ();

  localparam int RamDepth  = 1024;
  localparam int WaitLimit = 200;

  logic       clk_i;
  logic       rst_i;
  logic       host_req_i;
  addr_t      host_addr_i;
  logic       host_we_i;
  be_t        host_be_i;
  data_t      host_wdata_i;
  logic       host_gnt_o;
  logic       host_rvalid_o;
  data_t      host_rdata_o;
  logic       host_err_o;
  logic       char_valid_o;
  logic [7:0] char_o;
  logic       halt_o;
  logic       timer_irq_o;

  // Expectations driven along with each request
  data_t      drv_rdata;
  logic       drv_err;
  logic       drv_chk;
  // Response due in the current cycle
  logic       pend_valid;
  data_t      pend_rdata;
  logic       pend_err;
  logic       pend_chk;
  logic       char_pend;
  logic [7:0] char_byte;
  logic       halt_seen;
  data_t      ram_model [int];
  data_t      last_rdata;
  data_t      mtime_prev;
  logic       have_mtime;
  int         issued;
  int         responses;
  int         checks;
  int         errors;

  simple_system #(.RamDepth(RamDepth)) u_simple_system (.*);

  always #2 clk_i = ~clk_i;

  function automatic data_t merge_enabled(data_t old_word, data_t new_word, be_t be);
    data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic int ram_word(addr_t addr);
    return int'((addr >> 2) % RamDepth);
  endfunction

  function automatic logic hits_ram(addr_t addr);
    return (addr & RamMask) == RamBase;
  endfunction

  task automatic check_word(string name, data_t got, data_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    host_req_i <= 1'b0;
  endtask

  task automatic drive_access(addr_t addr, logic we, be_t be, data_t wdata, data_t exp_rdata,
                              logic exp_err, logic chk);
    @(posedge clk_i);
    host_req_i   <= 1'b1;
    host_addr_i  <= addr;
    host_we_i    <= we;
    host_be_i    <= be;
    host_wdata_i <= wdata;
    drv_rdata    <= exp_rdata;
    drv_err      <= exp_err;
    drv_chk      <= chk;
    issued++;
  endtask

  task automatic drain_responses();
    int cycles;
    cycles = 0;
    idle_cycle();
    while (responses != issued && cycles < WaitLimit) begin
      idle_cycle();
      cycles++;
    end
    if (responses != issued) begin
      errors++;
      $display("Timeout at %0t: %0d responses never arrived", $time, issued - responses);
    end
  endtask

  task automatic await_irq_level(logic level);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (timer_irq_o !== level && cycles < WaitLimit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (timer_irq_o !== level) begin
      errors++;
      $display("Timeout at %0t: timer_irq_o never became %b", $time, level);
    end
  endtask

  // R/W get a random idle gap, RB/WB follow the previous request directly
  task automatic run_line(string op, addr_t addr, be_t be, data_t wdata, data_t exp_rdata,
                          logic exp_err, logic chk);
    int    gap;
    data_t expected;
    data_t old_word;
    gap      = 0;
    expected = exp_rdata;
    old_word = '0;
    if (op == "R" || op == "W") gap = $urandom % 4;
    if (op == "T" || op == "C" || op == "I") drain_responses();
    repeat (gap) idle_cycle();
    if (op == "R" || op == "RB") begin
      if (hits_ram(addr) && ram_model.exists(ram_word(addr))) expected = ram_model[ram_word(addr)];
      drive_access(addr, 1'b0, be, wdata, expected, exp_err, chk);
    end else if (op == "W" || op == "WB") begin
      if (hits_ram(addr)) begin
        if (ram_model.exists(ram_word(addr))) old_word = ram_model[ram_word(addr)];
        ram_model[ram_word(addr)] = merge_enabled(old_word, wdata, be);
      end
      drive_access(addr, 1'b1, be, wdata, '0, exp_err, 1'b0);
    end else if (op == "T") begin
      drive_access(addr, 1'b0, be, wdata, '0, exp_err, 1'b0);
      drain_responses();
      if (have_mtime) begin
        checks++;
        assert (last_rdata > mtime_prev) else begin
          errors++;
          $display("CHECK FAILED at %0t: host_rdata_o (mtime low) is %h, expected above %h",
                   $time, last_rdata, mtime_prev);
        end
      end
      mtime_prev = last_rdata;
      have_mtime = 1'b1;
    end else if (op == "C") begin
      // Compare value placed a little ahead of the last mtime read
      drive_access(addr, 1'b1, be, mtime_prev + wdata, '0, exp_err, 1'b0);
    end else if (op == "I") begin
      await_irq_level(wdata[0]);
    end else begin
      errors++;
      $display("Unknown operation %s in the test file", op);
    end
  endtask

  // Response, character, halt and grant checks between clock edges
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (pend_valid) begin
        compare_bit("host_rvalid_o", host_rvalid_o, 1'b1);
        compare_bit("host_err_o", host_err_o, pend_err);
        if (pend_chk) check_word("host_rdata_o", host_rdata_o, pend_rdata);
        last_rdata = host_rdata_o;
        responses++;
      end else begin
        compare_bit("host_rvalid_o", host_rvalid_o, 1'b0);
        compare_bit("host_err_o", host_err_o, 1'b0);
      end
      compare_bit("char_valid_o", char_valid_o, char_pend);
      if (char_pend) check_word("char_o", data_t'(char_o), data_t'(char_byte));
      compare_bit("halt_o", halt_o, halt_seen);
      compare_bit("host_gnt_o", host_gnt_o, host_req_i);
      // Request granted in this cycle answers in the next
      pend_valid = host_req_i;
      pend_rdata = drv_rdata;
      pend_err   = drv_err;
      pend_chk   = drv_chk;
      char_pend  = host_req_i && host_we_i && host_be_i[0] && host_addr_i == SimCtrlBase;
      char_byte  = host_wdata_i[7:0];
      if (host_req_i && host_we_i && host_addr_i == SimCtrlBase + 32'd8) halt_seen = 1'b1;
    end
  end

  initial begin
    int    fd;
    int    n;
    string line;
    string op;
    addr_t addr;
    be_t   be;
    data_t wdata;
    data_t exp_rdata;
    int    exp_err;
    int    chk;
    void'($urandom(7));
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    host_req_i   = 1'b0;
    host_addr_i  = '0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_wdata_i = '0;
    drv_rdata    = '0;
    drv_err      = 1'b0;
    drv_chk      = 1'b0;
    pend_valid   = 1'b0;
    char_pend    = 1'b0;
    halt_seen    = 1'b0;
    have_mtime   = 1'b0;
    issued       = 0;
    responses    = 0;
    checks       = 0;
    errors       = 0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    fd = $fopen("verif/simple_system_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open verif/simple_system_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
        n = $sscanf(line, "%s %h %h %h %h %d %d", op, addr, be, wdata, exp_rdata, exp_err, chk);
        if (n != 7) begin
          errors++;
          $display("Malformed line in the test file: %s", line);
          continue;
        end
        run_line(op, addr, be, wdata, exp_rdata, exp_err != 0, chk != 0);
      end
      $fclose(fd);
    end
    drain_responses();
    repeat (2) idle_cycle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Guards against a stuck run
  initial begin
    #40000;
    $display("Timeout: the run did not finish, checks: %0d, errors: %0d", checks, errors);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: design/simple_system.sv
`timescale 1ns/1ns
// Memory-mapped system without a core; the host data port is exposed directly
// Map: RAM at 0x100000, simulator control at 0x20000, timer at 0x30000
module simple_system import simple_sys_pkg::*; #(
  parameter int RamDepth = 1024
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       host_req_i,
  input  addr_t      host_addr_i,
  input  logic       host_we_i,
  input  be_t        host_be_i,
  input  data_t      host_wdata_i,
  output logic       host_gnt_o,
  output logic       host_rvalid_o,
  output data_t      host_rdata_o,
  output logic       host_err_o,
  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o,
  output logic       timer_irq_o
);

  // One port per device
  dev_bus_if ram_bus ();
  dev_bus_if sim_ctrl_bus ();
  dev_bus_if timer_bus ();

  addr_bus u_bus (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .ram_o         (ram_bus.ctrl),
    .sim_ctrl_o    (sim_ctrl_bus.ctrl),
    .timer_o       (timer_bus.ctrl)
  );

  sram_1p #(
    .RamDepth (RamDepth)
  ) u_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (ram_bus.dev)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .bus          (sim_ctrl_bus.dev),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  mtimer u_timer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus         (timer_bus.dev),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// File: design/mtimer.sv
`timescale 1ns/1ns
// mtime counts every clock, a write to mtime replaces the increment for that cycle
// Offsets above 0xC in the window answer with err and zero data
module mtimer import simple_sys_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  dev_bus_if.dev bus,
  output logic   timer_irq_o
);

  localparam reg_off_t MtimeLoOff = 8'd0;
  localparam reg_off_t MtimeHiOff = 8'd1;
  localparam reg_off_t CmpLoOff   = 8'd2;
  localparam reg_off_t CmpHiOff   = 8'd3;

  mtime_t   mtime_q;
  mtime_t   mtime_d;
  mtime_t   mtimecmp_q;
  mtime_t   mtimecmp_d;
  reg_off_t word_off;
  logic     wr_en;
  data_t    rdata_d;
  logic     off_ok;
  logic     rvalid_q;
  logic     err_q;

  assign word_off = bus.addr[$bits(reg_off_t)+1:2];
  assign wr_en    = bus.req & bus.we;

  // Next register values, byte writes on either half
  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (word_off)
        MtimeLoOff: mtime_d = {mtime_q[63:32], merge_bytes(mtime_q[31:0], bus.wdata, bus.be)};
        MtimeHiOff: mtime_d = {merge_bytes(mtime_q[63:32], bus.wdata, bus.be), mtime_q[31:0]};
        CmpLoOff: begin
          mtimecmp_d = {mtimecmp_q[63:32], merge_bytes(mtimecmp_q[31:0], bus.wdata, bus.be)};
        end
        CmpHiOff: begin
          mtimecmp_d = {merge_bytes(mtimecmp_q[63:32], bus.wdata, bus.be), mtimecmp_q[31:0]};
        end
        default: ;
      endcase
    end
  end

  // Read mux on the current values
  always_comb begin
    off_ok  = 1'b1;
    rdata_d = '0;
    case (word_off)
      MtimeLoOff: rdata_d = mtime_q[31:0];
      MtimeHiOff: rdata_d = mtime_q[63:32];
      CmpLoOff:   rdata_d = mtimecmp_q[31:0];
      CmpHiOff:   rdata_d = mtimecmp_q[63:32];
      default:    off_ok  = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
      rvalid_q    <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      // Level interrupt, cleared by moving mtimecmp ahead
      timer_irq_o <= mtime_q >= mtimecmp_q;
      rvalid_q    <= bus.req;
      err_q       <= bus.req & ~off_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      bus.rdata <= rdata_d;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.err    = err_q;

endmodule

// File: design/sim_ctrl.sv
`timescale 1ns/1ns
// Offset 0 takes a character from byte 0, offset 8 halts until reset
// Reads return zero and never error
module sim_ctrl import simple_sys_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  dev_bus_if.dev     bus,
  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o
);

  localparam reg_off_t CharOff = 8'd0;
  localparam reg_off_t HaltOff = 8'd2;

  reg_off_t word_off;
  logic     wr_char;
  logic     wr_halt;
  logic     rvalid_q;

  assign word_off = bus.addr[$bits(reg_off_t)+1:2];
  assign wr_char  = bus.req & bus.we & bus.be[0] & (word_off == CharOff);
  assign wr_halt  = bus.req & bus.we & (word_off == HaltOff);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      char_valid_o <= 1'b0;
      halt_o       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      char_valid_o <= wr_char;
      rvalid_q     <= bus.req;
      // Sticky
      if (wr_halt) begin
        halt_o <= 1'b1;
      end
    end
  end

  // Character byte, valid only with the strobe
  always_ff @(posedge clk_i) begin
    if (wr_char) begin
      char_o <= bus.wdata[7:0];
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = '0;
  assign bus.err    = 1'b0;

endmodule

// File: design/sram_1p.sv
`timescale 1ns/1ns
// RamDepth must be a power of two, at least 2; word addresses wrap modulo RamDepth
// Contents are not initialized
module sram_1p import simple_sys_pkg::*; #(
  parameter int RamDepth = 1024
) (
  input  logic   clk_i,
  input  logic   rst_i,
  dev_bus_if.dev bus
);

  localparam int IdxW = $clog2(RamDepth);

  data_t           mem [RamDepth];
  logic [IdxW-1:0] word_idx;
  logic            rvalid_q;

  // Byte address to word index, upper bits dropped
  assign word_idx = bus.addr[IdxW+1:2];

  // Read sees the old word when a write hits the same address
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        mem[word_idx] <= merge_bytes(mem[word_idx], bus.wdata, bus.be);
      end
      bus.rdata <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.err    = 1'b0;

endmodule

// File: design/addr_bus.sv
`timescale 1ns/1ns
// Single host, three devices, never refuses a request (gnt follows req)
// Unmapped addresses are answered by the bus with err set and zero data
module addr_bus import simple_sys_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    host_req_i,
  input  addr_t   host_addr_i,
  input  logic    host_we_i,
  input  be_t     host_be_i,
  input  data_t   host_wdata_i,
  output logic    host_gnt_o,
  output logic    host_rvalid_o,
  output data_t   host_rdata_o,
  output logic    host_err_o,
  dev_bus_if.ctrl ram_o,
  dev_bus_if.ctrl sim_ctrl_o,
  dev_bus_if.ctrl timer_o
);

  logic [NrDevices-1:0] hit;
  dev_idx_t             sel_dev;
  logic                 mapped;
  dev_idx_t             resp_dev_q;
  logic                 resp_pend_q;
  logic                 unmapped_q;

  assign host_gnt_o = host_req_i;

  // Window match per device
  assign hit[DevRam]     = (host_addr_i & RamMask) == RamBase;
  assign hit[DevSimCtrl] = (host_addr_i & SimCtrlMask) == SimCtrlBase;
  assign hit[DevTimer]   = (host_addr_i & TimerMask) == TimerBase;

  // Lowest matching index wins, windows are disjoint anyway
  always_comb begin
    sel_dev = DevRam;
    mapped  = 1'b0;
    for (int d = 0; d < NrDevices; d++) begin
      if (hit[d] && !mapped) begin
        sel_dev = dev_idx_t'(d);
        mapped  = 1'b1;
      end
    end
  end

  assign ram_o.req      = host_req_i & hit[DevRam];
  assign sim_ctrl_o.req = host_req_i & hit[DevSimCtrl];
  assign timer_o.req    = host_req_i & hit[DevTimer];

  // Request payload goes to every device, only req is decoded
  assign ram_o.we         = host_we_i;
  assign ram_o.be         = host_be_i;
  assign ram_o.addr       = host_addr_i;
  assign ram_o.wdata      = host_wdata_i;
  assign sim_ctrl_o.we    = host_we_i;
  assign sim_ctrl_o.be    = host_be_i;
  assign sim_ctrl_o.addr  = host_addr_i;
  assign sim_ctrl_o.wdata = host_wdata_i;
  assign timer_o.we       = host_we_i;
  assign timer_o.be       = host_be_i;
  assign timer_o.addr     = host_addr_i;
  assign timer_o.wdata    = host_wdata_i;

  // Remember who answers next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_pend_q <= 1'b0;
      unmapped_q  <= 1'b0;
      resp_dev_q  <= DevRam;
    end else begin
      resp_pend_q <= host_req_i & mapped;
      unmapped_q  <= host_req_i & ~mapped;
      if (host_req_i) begin
        resp_dev_q <= sel_dev;
      end
    end
  end

  // Response select, bus-generated error when nothing matched
  always_comb begin
    host_rvalid_o = unmapped_q;
    host_rdata_o  = '0;
    host_err_o    = unmapped_q;
    if (resp_pend_q) begin
      case (resp_dev_q)
        DevRam: begin
          host_rvalid_o = ram_o.rvalid;
          host_rdata_o  = ram_o.rdata;
          host_err_o    = ram_o.err;
        end
        DevSimCtrl: begin
          host_rvalid_o = sim_ctrl_o.rvalid;
          host_rdata_o  = sim_ctrl_o.rdata;
          host_err_o    = sim_ctrl_o.err;
        end
        DevTimer: begin
          host_rvalid_o = timer_o.rvalid;
          host_rdata_o  = timer_o.rdata;
          host_err_o    = timer_o.err;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: design/dev_bus_if.sv
`timescale 1ns/1ns
// One bus-to-device port; req is a single-cycle strobe per access
// The device answers with rvalid exactly one cycle after req
interface dev_bus_if import simple_sys_pkg::*; ();

  logic  req;
  logic  we;
  be_t   be;
  addr_t addr;
  data_t wdata;
  logic  rvalid;
  data_t rdata;
  logic  err;

  // Bus end
  modport ctrl (
    output req, we, be, addr, wdata,
    input  rvalid, rdata, err
  );

  // Device end
  modport dev (
    input  req, we, be, addr, wdata,
    output rvalid, rdata, err
  );

endinterface

// File: design/simple_sys_pkg.sv
// Bus types, device indices and the address map of the memory-mapped system
// Each base must be aligned to its window and the windows must not overlap
package simple_sys_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [1:0]  dev_idx_t;
  typedef logic [63:0] mtime_t;
  // Word offset inside a 1 kB register window
  typedef logic [7:0]  reg_off_t;

  localparam int NrDevices = 3;

  localparam dev_idx_t DevRam     = 2'd0;
  localparam dev_idx_t DevSimCtrl = 2'd1;
  localparam dev_idx_t DevTimer   = 2'd2;

  // 1 MB RAM window
  localparam addr_t RamBase     = 32'h0010_0000;
  localparam addr_t RamMask     = ~32'h000F_FFFF;
  // 1 kB register windows
  localparam addr_t SimCtrlBase = 32'h0002_0000;
  localparam addr_t SimCtrlMask = ~32'h0000_03FF;
  localparam addr_t TimerBase   = 32'h0003_0000;
  localparam addr_t TimerMask   = ~32'h0000_03FF;

  // Replace only the enabled bytes of a word
  function automatic data_t merge_bytes(data_t old_data, data_t new_data, be_t be);
    data_t merged;
    merged = old_data;
    for (int i = 0; i < $bits(be_t); i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage
